// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := proc_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/proc_props.sv ====
// Bound assertions for the processor top level
//   Commit port quiet in the cycle after reset
//   Sticky err flag
//   No commits once halted
`timescale 1ns/10ps
`default_nettype none

module procProps (
   input wire clk,
   input wire rst,
   input wire wbEn,
   input wire halted,
   input wire err
);

   // Reset clears MEM/WB, so nothing commits on the next cycle
   assert property (@(posedge clk) rst |=> !wbEn)
      else $error("wbEn high in the cycle after reset");

   assert property (@(posedge clk) (err && !rst) |=> err)
      else $error("err fell without reset");

   // Drained and stopped core stays quiet
   assert property (@(posedge clk) (halted && !rst) |=> !wbEn)
      else $error("wbEn rose after halted");

endmodule

bind proc procProps props (
   .clk(clk),
   .rst(rst),
   .wbEn(wbEn),
   .halted(halted),
   .err(err)
);

`default_nettype wire

// ==== dv/proc_tb.sv ====
// Testbench for the pipelined processor
//   Table of programs with expected commit streams and err
//   Program load, run until halted, commit and err checks
`timescale 1ns/10ps
`default_nettype none

module proc_tb;

   localparam int NUM_TESTS = 6;
   localparam int PROG_LEN = 12;
   localparam int MAX_COMMITS = 12;
   localparam int TIMEOUT = 300;

   logic clk, rst, run, imemWrEn;
   procPkg::imemAddr_t imemAddr;
   procPkg::word_t imemData;
   logic err, halted, wbEn;
   procPkg::regIdx_t wbReg;
   procPkg::word_t wbData;

   procPkg::word_t progTable [NUM_TESTS][PROG_LEN];
   int progCount [NUM_TESTS];
   procPkg::regIdx_t expReg [NUM_TESTS][MAX_COMMITS];
   procPkg::word_t expVal [NUM_TESTS][MAX_COMMITS];
   int expCount [NUM_TESTS];
   logic expErr [NUM_TESTS];
   string testName [NUM_TESTS];
   int checkErrors = 0;
   int failedTests = 0;

   proc DUT (
      .clk(clk),
      .rst(rst),
      .run(run),
      .imemWrEn(imemWrEn),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .err(err),
      .halted(halted),
      .wbEn(wbEn),
      .wbReg(wbReg),
      .wbData(wbData)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic procPkg::word_t sext8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic procPkg::word_t sext6(input logic [5:0] v);
      return {{10{v[5]}}, v};
   endfunction

   // Instruction encoders
   function automatic procPkg::word_t encR(input procPkg::opcode_t op, input procPkg::regIdx_t rd,
                                           input procPkg::regIdx_t rs, input procPkg::regIdx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic procPkg::word_t encI(input procPkg::opcode_t op, input procPkg::regIdx_t rd,
                                           input procPkg::regIdx_t rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic procPkg::word_t encLbi(input procPkg::regIdx_t rd, input logic [7:0] imm);
      return {procPkg::OP_LBI, rd, 1'b0, imm};
   endfunction

   function automatic procPkg::word_t encBr(input procPkg::opcode_t op, input procPkg::regIdx_t rd,
                                            input logic [8:0] off);
      return {op, rd, off};
   endfunction

   task automatic addWord(input int t, input procPkg::word_t w);
      progTable[t][progCount[t]] = w;
      progCount[t]++;
   endtask

   task automatic addCommit(input int t, input procPkg::regIdx_t r, input procPkg::word_t v);
      expReg[t][expCount[t]] = r;
      expVal[t][expCount[t]] = v;
      expCount[t]++;
   endtask

   task automatic buildTable();
      logic [7:0] immA;
      logic [7:0] immC;
      logic [5:0] immB;
      procPkg::word_t r1, r2, r3, r4, r5, r6, r7;
      for (int t = 0; t < NUM_TESTS; t++) begin
         progCount[t] = 0;
         expCount[t] = 0;
         expErr[t] = 1'b0;
         for (int i = 0; i < PROG_LEN; i++) begin
            progTable[t][i] = {procPkg::OP_HALT, 12'd0};
         end
      end
      immA = 8'($urandom);
      immB = 6'($urandom);
      immC = 8'($urandom);
      r1 = sext8(immA);
      r2 = r1 + sext6(immB);
      r3 = r1 + r2;
      r4 = r3 - r1;
      r5 = r4 & r3;
      r6 = r5 ^ r3;
      r7 = sext8(immC) + r6;
      testName[0] = "alu forwarding";
      addWord(0, encLbi(3'd1, immA));
      addWord(0, encI(procPkg::OP_ADDI, 3'd2, 3'd1, immB));
      addWord(0, encR(procPkg::OP_ADD, 3'd3, 3'd1, 3'd2));
      addWord(0, encR(procPkg::OP_SUB, 3'd4, 3'd3, 3'd1));
      addWord(0, encR(procPkg::OP_AND, 3'd5, 3'd4, 3'd3));
      addWord(0, encR(procPkg::OP_XOR, 3'd6, 3'd5, 3'd3));
      addWord(0, encLbi(3'd7, immC));
      addWord(0, encR(procPkg::OP_ADD, 3'd7, 3'd7, 3'd6));
      addCommit(0, 3'd1, r1);
      addCommit(0, 3'd2, r2);
      addCommit(0, 3'd3, r3);
      addCommit(0, 3'd4, r4);
      addCommit(0, 3'd5, r5);
      addCommit(0, 3'd6, r6);
      addCommit(0, 3'd7, sext8(immC));
      addCommit(0, 3'd7, r7);
      // Stores then loads, each load used right away
      testName[1] = "memory load-use";
      addWord(1, encLbi(3'd1, 8'd25));
      addWord(1, encLbi(3'd2, 8'd3));
      addWord(1, encI(procPkg::OP_ST, 3'd1, 3'd2, 6'd4));
      addWord(1, encI(procPkg::OP_LD, 3'd3, 3'd2, 6'd4));
      addWord(1, encR(procPkg::OP_ADD, 3'd4, 3'd3, 3'd1));
      addWord(1, encLbi(3'd5, 8'hFE));
      addWord(1, encI(procPkg::OP_ST, 3'd5, 3'd0, 6'd10));
      addWord(1, encI(procPkg::OP_LD, 3'd6, 3'd0, 6'd10));
      addWord(1, encR(procPkg::OP_SUB, 3'd7, 3'd6, 3'd4));
      addCommit(1, 3'd1, 16'd25);
      addCommit(1, 3'd2, 16'd3);
      addCommit(1, 3'd3, 16'd25);
      addCommit(1, 3'd4, 16'd50);
      addCommit(1, 3'd5, 16'hFFFE);
      addCommit(1, 3'd6, 16'hFFFE);
      addCommit(1, 3'd7, 16'hFFCC);
      // r7 writes sit on flushed slots and must never commit
      testName[2] = "control flow";
      addWord(2, encLbi(3'd1, 8'd0));
      addWord(2, encBr(procPkg::OP_BEQZ, 3'd1, 9'd1));
      addWord(2, encLbi(3'd7, 8'd99));
      addWord(2, encLbi(3'd2, 8'd5));
      addWord(2, encBr(procPkg::OP_BNEZ, 3'd2, 9'd1));
      addWord(2, encLbi(3'd7, 8'd98));
      addWord(2, encBr(procPkg::OP_BEQZ, 3'd2, 9'd5));
      addWord(2, encBr(procPkg::OP_BNEZ, 3'd1, 9'd4));
      addWord(2, {procPkg::OP_J, 12'd1});
      addWord(2, encLbi(3'd7, 8'd97));
      addWord(2, encR(procPkg::OP_ADD, 3'd3, 3'd2, 3'd2));
      addCommit(2, 3'd1, 16'd0);
      addCommit(2, 3'd2, 16'd5);
      addCommit(2, 3'd3, 16'd10);
      testName[3] = "illegal opcode";
      addWord(3, encLbi(3'd1, 8'd4));
      addWord(3, encI(procPkg::OP_ADDI, 3'd2, 3'd1, 6'd1));
      addWord(3, 16'hD000);
      addWord(3, encLbi(3'd3, 8'd1));
      addCommit(3, 3'd1, 16'd4);
      addCommit(3, 3'd2, 16'd5);
      expErr[3] = 1'b1;
      testName[4] = "halt";
      addWord(4, encLbi(3'd1, 8'd9));
      addWord(4, {procPkg::OP_HALT, 12'd0});
      addWord(4, encLbi(3'd2, 8'd1));
      addWord(4, encR(procPkg::OP_ADD, 3'd3, 3'd1, 3'd1));
      addCommit(4, 3'd1, 16'd9);
      // Sources written by earlier tests read as zero after reset
      testName[5] = "reload";
      addWord(5, encR(procPkg::OP_ADD, 3'd1, 3'd3, 3'd4));
      addWord(5, encI(procPkg::OP_ADDI, 3'd2, 3'd7, 6'd3));
      addWord(5, encR(procPkg::OP_XOR, 3'd5, 3'd1, 3'd2));
      addCommit(5, 3'd1, 16'd0);
      addCommit(5, 3'd2, 16'd3);
      addCommit(5, 3'd5, 16'd3);
   endtask

   task automatic runTest(input int t);
      int commits;
      int cycles;
      int errorsBefore;
      bit done;
      errorsBefore = checkErrors;
      commits = 0;
      cycles = 0;
      done = 1'b0;
      @(posedge clk);
      #5;
      rst = 1'b1;
      run = 1'b0;
      repeat (4) begin
         @(posedge clk);
         #5;
      end
      rst = 1'b0;
      for (int i = 0; i < PROG_LEN; i++) begin
         imemWrEn = 1'b1;
         imemAddr = procPkg::imemAddr_t'(i);
         imemData = progTable[t][i];
         @(posedge clk);
         #5;
      end
      imemWrEn = 1'b0;
      run = 1'b1;
      // Illegal opcodes stop the core too, so halted ends every run
      while (!done && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (wbEn) begin
            if (commits >= expCount[t]) begin
               $display("Test %0d: unexpected extra commit to r%0d at %0t", t, wbReg, $time);
               checkErrors++;
            end else begin
               if (wbReg !== expReg[t][commits]) begin
                  $display("MISMATCH %0t wbReg: got %0d expected %0d",
                           $time, wbReg, expReg[t][commits]);
                  checkErrors++;
               end
               if (wbData !== expVal[t][commits]) begin
                  $display("MISMATCH %0t wbData: got %h expected %h",
                           $time, wbData, expVal[t][commits]);
                  checkErrors++;
               end
            end
            commits++;
         end
         if (halted) begin
            done = 1'b1;
         end
      end
      if (!done) begin
         $display("Test %0d: timed out after %0d cycles without halted", t, cycles);
         checkErrors++;
      end
      if (commits < expCount[t]) begin
         $display("Test %0d: missing commits, saw %0d of %0d", t, commits, expCount[t]);
         checkErrors++;
      end
      if (err !== expErr[t]) begin
         $display("MISMATCH %0t err: got %b expected %b", $time, err, expErr[t]);
         checkErrors++;
      end
      if (checkErrors != errorsBefore) begin
         failedTests++;
      end
      $display("Test %0d (%s): %s, %0d commits in %0d cycles", t, testName[t],
               (checkErrors == errorsBefore) ? "ok" : "FAILED", commits, cycles);
   endtask

   initial begin
      rst = 1'b1;
      run = 1'b0;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      void'($urandom(50));
      buildTable();
      for (int t = 0; t < NUM_TESTS; t++) begin
         runTest(t);
      end
      $display("Tests run: %0d, failed: %0d, check errors: %0d",
               NUM_TESTS, failedTests, checkErrors);
      if (checkErrors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/procPkg.sv
logic/fetch.sv
logic/decode.sv
logic/hazard.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
dv/proc_props.sv
dv/proc_tb.sv

// ==== logic/decode.sv ====
// Decode stage
//   Instruction decoder and 8-entry register file
//   Branch and jump resolution with its own operand bypass
//   Sticky stop and illegal-opcode error, ID/EX register
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module decode (
   input  wire                clk,
   input  wire                rst,
   input  wire                stall,
   input  wire                ifidValid,
   input  procPkg::word_t     ifidInstr,
   input  procPkg::imemAddr_t ifidPc,
   input  wire                memwbValid,
   input  wire                memwbRegWrite,
   input  procPkg::regIdx_t   memwbRd,
   input  procPkg::word_t     memwbData,
   input  procPkg::word_t     exmemAluResult,
   input  procPkg::regIdx_t   exmemRd,
   input  wire                exmemValid,
   input  wire                exmemRegWrite,
   input  wire                exmemMemRead,
   output logic               redirect,
   output procPkg::imemAddr_t redirectPc,
   output logic               stopped,
   output logic               err,
   output procPkg::regIdx_t   idRs,
   output procPkg::regIdx_t   idRt,
   output procPkg::regIdx_t   idBranchReg,
   output logic               idUsesRs,
   output logic               idUsesRt,
   output logic               idIsBranch,
   output logic               idexValid,
   output logic               idexRegWrite,
   output logic               idexMemRead,
   output logic               idexMemWrite,
   output procPkg::aluOp_t    idexAluOp,
   output logic               idexAluSrc,
   output procPkg::regIdx_t   idexRd,
   output procPkg::regIdx_t   idexRs,
   output procPkg::regIdx_t   idexRt,
   output procPkg::word_t     idexRsVal,
   output procPkg::word_t     idexRtVal,
   output procPkg::word_t     idexImm,
   output logic               idexIsLbi
);

   procPkg::word_t regs [`PROC_REG_CNT];
   procPkg::opcode_t op;
   procPkg::regIdx_t rd;
   procPkg::word_t imm, rsVal, rtVal, rdVal, brVal, brOff, target;
   procPkg::aluOp_t aluOp;
   logic idValid, advance, wbHit;
   logic regWrite, memRead, memWrite, aluSrc, isLbi, usesRs, usesRt;
   logic isBranch, isJump, isHalt, illegal, taken;

   assign op      = ifidInstr[15:12];
   assign rd      = ifidInstr[11:9];
   assign idValid = ifidValid && !stopped;
   assign advance = idValid && !stall;

   always_comb begin
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      aluOp    = procPkg::ALU_ADD;
      aluSrc   = 1'b0;
      isLbi    = 1'b0;
      usesRs   = 1'b0;
      usesRt   = 1'b0;
      isBranch = 1'b0;
      isJump   = 1'b0;
      isHalt   = 1'b0;
      illegal  = 1'b0;
      imm      = procPkg::word_t'($signed(ifidInstr[5:0]));
      case (op)
         procPkg::OP_NOP: ;
         procPkg::OP_HALT: isHalt = 1'b1;
         procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND, procPkg::OP_XOR: begin
            regWrite = 1'b1;
            usesRs   = 1'b1;
            usesRt   = 1'b1;
            aluOp    = procPkg::aluOp_t'(op - procPkg::OP_ADD);
         end
         procPkg::OP_ADDI: begin
            regWrite = 1'b1;
            usesRs   = 1'b1;
            aluSrc   = 1'b1;
         end
         procPkg::OP_LBI: begin
            regWrite = 1'b1;
            isLbi    = 1'b1;
            imm      = procPkg::word_t'($signed(ifidInstr[7:0]));
         end
         procPkg::OP_LD: begin
            regWrite = 1'b1;
            memRead  = 1'b1;
            usesRs   = 1'b1;
            aluSrc   = 1'b1;
         end
         procPkg::OP_ST: begin
            // Store data rides the second operand slot
            memWrite = 1'b1;
            usesRs   = 1'b1;
            usesRt   = 1'b1;
            aluSrc   = 1'b1;
         end
         procPkg::OP_BEQZ, procPkg::OP_BNEZ: isBranch = 1'b1;
         procPkg::OP_J: isJump = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   assign idRs        = ifidInstr[8:6];
   assign idRt        = (op == procPkg::OP_ST) ? rd : ifidInstr[5:3];
   assign idBranchReg = rd;
   assign idUsesRs    = idValid && usesRs;
   assign idUsesRt    = idValid && usesRt;
   assign idIsBranch  = idValid && isBranch;

   // Register file reads see a same-cycle write
   assign wbHit = memwbValid && memwbRegWrite;
   assign rsVal = (wbHit && memwbRd == idRs) ? memwbData : regs[idRs];
   assign rtVal = (wbHit && memwbRd == idRt) ? memwbData : regs[idRt];
   assign rdVal = (wbHit && memwbRd == rd) ? memwbData : regs[rd];

   // Branch register bypass from a non-load in EX/MEM
   assign brVal = (exmemValid && exmemRegWrite && !exmemMemRead && exmemRd == rd) ?
                  exmemAluResult : rdVal;

   assign taken = isJump ||
                  (isBranch && ((op == procPkg::OP_BEQZ) == (brVal == '0)));
   assign brOff = isJump ? procPkg::word_t'($signed(ifidInstr[11:0])) :
                           procPkg::word_t'($signed(ifidInstr[8:0]));
   assign target     = procPkg::word_t'(ifidPc) + procPkg::word_t'(1) + brOff;
   assign redirect   = advance && taken;
   assign redirectPc = procPkg::imemAddr_t'(target);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PROC_REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wbHit) begin
         regs[memwbRd] <= memwbData;
      end
   end

   // Sticky stop and error, cleared only by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         stopped <= 1'b0;
         err     <= 1'b0;
      end else begin
         stopped <= stopped || (idValid && (isHalt || illegal));
         err     <= err || (idValid && illegal);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         idexValid    <= 1'b0;
         idexRegWrite <= 1'b0;
         idexMemRead  <= 1'b0;
         idexMemWrite <= 1'b0;
      end else begin
         idexValid    <= advance && !illegal;
         idexRegWrite <= advance && regWrite;
         idexMemRead  <= advance && memRead;
         idexMemWrite <= advance && memWrite;
      end
   end

   always_ff @(posedge clk) begin
      idexAluOp  <= aluOp;
      idexAluSrc <= aluSrc;
      idexIsLbi  <= isLbi;
      idexRd     <= rd;
      idexRs     <= idRs;
      idexRt     <= idRt;
      idexRsVal  <= rsVal;
      idexRtVal  <= rtVal;
      idexImm    <= imm;
   end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
// Execute stage
//   Operand forwarding multiplexers and the ALU
//   EX/MEM pipeline register
`timescale 1ns/10ps
`default_nettype none

module execute (
   input  wire               clk,
   input  wire               rst,
   input  procPkg::fwdSel_t  fwdA,
   input  procPkg::fwdSel_t  fwdB,
   input  wire               idexValid,
   input  wire               idexRegWrite,
   input  wire               idexMemRead,
   input  wire               idexMemWrite,
   input  procPkg::aluOp_t   idexAluOp,
   input  wire               idexAluSrc,
   input  procPkg::regIdx_t  idexRd,
   input  procPkg::word_t    idexRsVal,
   input  procPkg::word_t    idexRtVal,
   input  procPkg::word_t    idexImm,
   input  wire               idexIsLbi,
   input  procPkg::word_t    memwbData,
   output logic              exmemValid,
   output logic              exmemRegWrite,
   output logic              exmemMemRead,
   output logic              exmemMemWrite,
   output procPkg::regIdx_t  exmemRd,
   output procPkg::word_t    exmemAluResult,
   output procPkg::word_t    exmemStoreData
);

   procPkg::word_t opA, opB, aluB, result;

   assign opA = (fwdA == procPkg::FWD_EXMEM) ? exmemAluResult :
                (fwdA == procPkg::FWD_MEMWB) ? memwbData : idexRsVal;
   assign opB = (fwdB == procPkg::FWD_EXMEM) ? exmemAluResult :
                (fwdB == procPkg::FWD_MEMWB) ? memwbData : idexRtVal;

   assign aluB = idexAluSrc ? idexImm : opB;

   always_comb begin
      case (idexAluOp)
         procPkg::ALU_SUB: result = opA - aluB;
         procPkg::ALU_AND: result = opA & aluB;
         procPkg::ALU_XOR: result = opA ^ aluB;
         default:          result = opA + aluB;
      endcase
      // LBI just passes its immediate
      if (idexIsLbi) begin
         result = idexImm;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         exmemValid    <= 1'b0;
         exmemRegWrite <= 1'b0;
         exmemMemRead  <= 1'b0;
         exmemMemWrite <= 1'b0;
      end else begin
         exmemValid    <= idexValid;
         exmemRegWrite <= idexValid && idexRegWrite;
         exmemMemRead  <= idexValid && idexMemRead;
         exmemMemWrite <= idexValid && idexMemWrite;
      end
   end

   always_ff @(posedge clk) begin
      exmemRd        <= idexRd;
      exmemAluResult <= result;
      exmemStoreData <= opB;
   end

endmodule

`default_nettype wire

// ==== logic/fetch.sv ====
// Fetch stage
//   Program counter and instruction memory with load port
//   IF/ID pipeline register with flush on redirect
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module fetch (
   input  wire                clk,
   input  wire                rst,
   input  wire                run,
   input  wire                stall,
   input  wire                stopped,
   input  wire                redirect,
   input  procPkg::imemAddr_t redirectPc,
   input  wire                imemWrEn,
   input  procPkg::imemAddr_t imemAddr,
   input  procPkg::word_t     imemData,
   output logic               ifidValid,
   output procPkg::word_t     ifidInstr,
   output procPkg::imemAddr_t ifidPc
);

   procPkg::word_t imem [`PROC_IMEM_DEPTH];
   procPkg::imemAddr_t pc;
   logic advance;

   assign advance = run && !stall && !stopped;

   // Program load port
   always_ff @(posedge clk) begin
      if (imemWrEn) begin
         imem[imemAddr] <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= '0;
         ifidValid <= 1'b0;
      end else if (redirect) begin
         pc        <= redirectPc;
         ifidValid <= 1'b0;
      end else if (advance) begin
         pc        <= pc + procPkg::imemAddr_t'(1);
         ifidValid <= 1'b1;
      end else if (!stall) begin
         // Idle or stopped, so feed bubbles
         ifidValid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (advance && !redirect) begin
         ifidInstr <= imem[pc];
         ifidPc    <= pc;
      end
   end

endmodule

`default_nettype wire

// ==== logic/hazard.sv ====
// Hazard unit
//   Load-use and branch operand stall detection
//   Forwarding source selection for both execute operands
`timescale 1ns/10ps
`default_nettype none

module hazard (
   input  procPkg::regIdx_t idRs,
   input  procPkg::regIdx_t idRt,
   input  wire              idUsesRs,
   input  wire              idUsesRt,
   input  wire              idIsBranch,
   input  procPkg::regIdx_t idBranchReg,
   input  wire              idexValid,
   input  wire              idexRegWrite,
   input  wire              idexMemRead,
   input  procPkg::regIdx_t idexRd,
   input  procPkg::regIdx_t idexRs,
   input  procPkg::regIdx_t idexRt,
   input  wire              exmemValid,
   input  wire              exmemRegWrite,
   input  wire              exmemMemRead,
   input  procPkg::regIdx_t exmemRd,
   input  wire              memwbValid,
   input  wire              memwbRegWrite,
   input  procPkg::regIdx_t memwbRd,
   output logic             stall,
   output procPkg::fwdSel_t fwdA,
   output procPkg::fwdSel_t fwdB
);

   logic loadUse, branchWait, exFwd, wbFwd;

   assign loadUse = idexValid && idexMemRead &&
                    ((idUsesRs && idexRd == idRs) || (idUsesRt && idexRd == idRt));

   // Branches compare in decode, so the value must already sit in EX/MEM or later
   assign branchWait = idIsBranch &&
                       ((idexValid && idexRegWrite && idexRd == idBranchReg) ||
                        (exmemValid && exmemMemRead && exmemRd == idBranchReg));

   assign stall = loadUse || branchWait;

   assign exFwd = exmemValid && exmemRegWrite && !exmemMemRead;
   assign wbFwd = memwbValid && memwbRegWrite;

   // EX/MEM is younger and wins
   assign fwdA = (exFwd && exmemRd == idexRs) ? procPkg::FWD_EXMEM :
                 (wbFwd && memwbRd == idexRs) ? procPkg::FWD_MEMWB : procPkg::FWD_NONE;
   assign fwdB = (exFwd && exmemRd == idexRt) ? procPkg::FWD_EXMEM :
                 (wbFwd && memwbRd == idexRt) ? procPkg::FWD_MEMWB : procPkg::FWD_NONE;

endmodule

`default_nettype wire

// ==== logic/memory.sv ====
// Memory stage
//   Single-cycle data memory
//   Writeback value select and MEM/WB register
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module memory (
   input  wire              clk,
   input  wire              rst,
   input  wire              exmemValid,
   input  wire              exmemRegWrite,
   input  wire              exmemMemRead,
   input  wire              exmemMemWrite,
   input  procPkg::regIdx_t exmemRd,
   input  procPkg::word_t   exmemAluResult,
   input  procPkg::word_t   exmemStoreData,
   output logic             memwbValid,
   output logic             memwbRegWrite,
   output procPkg::regIdx_t memwbRd,
   output procPkg::word_t   memwbData
);

   procPkg::word_t dmem [`PROC_DMEM_DEPTH];
   procPkg::dmemAddr_t addr;
   procPkg::word_t wbValue;

   // Word address from the low ALU bits
   assign addr    = procPkg::dmemAddr_t'(exmemAluResult);
   assign wbValue = exmemMemRead ? dmem[addr] : exmemAluResult;

   always_ff @(posedge clk) begin
      if (exmemValid && exmemMemWrite) begin
         dmem[addr] <= exmemStoreData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         memwbValid    <= 1'b0;
         memwbRegWrite <= 1'b0;
      end else begin
         memwbValid    <= exmemValid;
         memwbRegWrite <= exmemValid && exmemRegWrite;
      end
   end

   always_ff @(posedge clk) begin
      memwbRd   <= exmemRd;
      memwbData <= wbValue;
   end

endmodule

`default_nettype wire

// ==== logic/proc.sv ====
// Five-stage pipelined processor top level
//   Fetch, decode, execute, memory stages and the hazard unit
//   Writeback commit port plus halted and err status
`timescale 1ns/10ps
`default_nettype none

module proc (
   input  wire                clk,
   input  wire                rst,
   input  wire                run,
   input  wire                imemWrEn,
   input  procPkg::imemAddr_t imemAddr,
   input  procPkg::word_t     imemData,
   output logic               err,
   output logic               halted,
   output logic               wbEn,
   output procPkg::regIdx_t   wbReg,
   output procPkg::word_t     wbData
);

   logic stall, stopped, redirect;
   procPkg::imemAddr_t redirectPc;

   logic ifidValid;
   procPkg::word_t ifidInstr;
   procPkg::imemAddr_t ifidPc;

   procPkg::regIdx_t idRs, idRt, idBranchReg;
   logic idUsesRs, idUsesRt, idIsBranch;

   logic idexValid, idexRegWrite, idexMemRead, idexMemWrite, idexAluSrc, idexIsLbi;
   procPkg::aluOp_t idexAluOp;
   procPkg::regIdx_t idexRd, idexRs, idexRt;
   procPkg::word_t idexRsVal, idexRtVal, idexImm;

   logic exmemValid, exmemRegWrite, exmemMemRead, exmemMemWrite;
   procPkg::regIdx_t exmemRd;
   procPkg::word_t exmemAluResult, exmemStoreData;

   logic memwbValid, memwbRegWrite;
   procPkg::regIdx_t memwbRd;
   procPkg::word_t memwbData;

   procPkg::fwdSel_t fwdA, fwdB;

   fetch fetchStage (.*);

   decode decodeStage (.*);

   hazard hazardUnit (.*);

   execute executeStage (.*);

   memory memoryStage (.*);

   // Commit port straight from MEM/WB
   assign wbEn   = memwbValid && memwbRegWrite;
   assign wbReg  = memwbRd;
   assign wbData = memwbData;

   // Stopped core reports halted once the last instruction has left MEM/WB
   assign halted = stopped && !idexValid && !exmemValid && !memwbValid;

endmodule

`default_nettype wire

// ==== logic/procPkg.sv ====
// Shared processor types
//   Word, register index and memory address types
//   Opcode constants, ALU operations, forwarding selects
`default_nettype none

`include "proc_settings.svh"

package procPkg;

   typedef logic [`PROC_DATA_W-1:0] word_t;
   typedef logic [2:0] regIdx_t;
   typedef logic [$clog2(`PROC_IMEM_DEPTH)-1:0] imemAddr_t;
   typedef logic [$clog2(`PROC_DMEM_DEPTH)-1:0] dmemAddr_t;

   // Instruction field [15:12]
   typedef logic [3:0] opcode_t;
   localparam opcode_t OP_NOP  = 4'd0;
   localparam opcode_t OP_HALT = 4'd1;
   localparam opcode_t OP_ADD  = 4'd2;
   localparam opcode_t OP_SUB  = 4'd3;
   localparam opcode_t OP_AND  = 4'd4;
   localparam opcode_t OP_XOR  = 4'd5;
   localparam opcode_t OP_ADDI = 4'd6;
   localparam opcode_t OP_LBI  = 4'd7;
   localparam opcode_t OP_LD   = 4'd8;
   localparam opcode_t OP_ST   = 4'd9;
   localparam opcode_t OP_BEQZ = 4'd10;
   localparam opcode_t OP_BNEZ = 4'd11;
   localparam opcode_t OP_J    = 4'd12;

   typedef logic [1:0] aluOp_t;
   localparam aluOp_t ALU_ADD = 2'd0;
   localparam aluOp_t ALU_SUB = 2'd1;
   localparam aluOp_t ALU_AND = 2'd2;
   localparam aluOp_t ALU_XOR = 2'd3;

   typedef logic [1:0] fwdSel_t;
   localparam fwdSel_t FWD_NONE  = 2'd0;
   localparam fwdSel_t FWD_EXMEM = 2'd1;
   localparam fwdSel_t FWD_MEMWB = 2'd2;

endpackage

`default_nettype wire

// ==== logic/proc_settings.svh ====
// Processor size settings
//   Data and instruction width
//   General register count
//   Instruction and data memory depths
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// One word holds both data and instructions
`define PROC_DATA_W 16

`define PROC_REG_CNT 8

// Depths in words, powers of two
`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64

`endif
